// ==== hw/wd_pkg.sv ====
`default_nettype none

package wd_pkg;

    // ========================================
    // Sizes
    // ========================================

    // Queues per type, one count each
    localparam int num_qid = 64;
    localparam int qid_w   = 6;

    // Idle count width, also the threshold width
    localparam int cnt_w   = 10;

    // ========================================
    // Encodings
    // ========================================

    // Selects the directed or the load-balanced count memory
    typedef enum logic {
        qtype_dir = 1'b0,
        qtype_ldb = 1'b1
    } qtype_t;

    // Operation carried down the count pipe
    typedef enum logic [1:0] {
        // Bubble
        op_none = 2'd0,
        // Init and dequeue, no read needed
        op_zero = 2'd1,
        // Sweep step, stops at the threshold
        op_incr = 2'd2,
        // Debug read, no write back
        op_read = 2'd3
    } rmw_op_t;

endpackage

`default_nettype wire

// ==== hw/wd_rmw_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface wd_rmw_if;

    // Read port, rdata valid one cycle after re
    logic                     re;
    logic [wd_pkg::qid_w-1:0] raddr;
    logic [wd_pkg::cnt_w-1:0] rdata;

    // Write port
    logic                     we;
    logic [wd_pkg::qid_w-1:0] waddr;
    logic [wd_pkg::cnt_w-1:0] wdata;

    modport pipe (
         output re
        ,output raddr
        ,output we
        ,output waddr
        ,output wdata
        ,input  rdata
    );

    modport mem (
         input  re
        ,input  raddr
        ,input  we
        ,input  waddr
        ,input  wdata
        ,output rdata
    );

endinterface

`default_nettype wire

// ==== hw/wd_rf_64x10.sv ====
`timescale 1ns/100ps
`default_nettype none

module wd_rf_64x10 (
     input  logic         clk
    ,input  logic         rst_n
    ,input  logic         isol_en
    ,input  logic         pwr_enable_b_in
    ,wd_rmw_if.mem        mem
    ,output logic         pwr_enable_b_out
);

    logic [wd_pkg::cnt_w-1:0] ram [wd_pkg::num_qid];
    logic [wd_pkg::cnt_w-1:0] rdata_q;
    logic                     blocked;

    // ========================================
    // Power switch model
    // ========================================

    // Switch settles one cycle after the request, off while in reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pwr_enable_b_out <= 1'b1;
        end else begin
            pwr_enable_b_out <= pwr_enable_b_in;
        end
    end

    assign blocked = pwr_enable_b_out | isol_en;

    // ========================================
    // Array
    // ========================================

    always_ff @(posedge clk) begin
        if (mem.we && !blocked) begin
            ram[mem.waddr] <= mem.wdata;
        end
        if (mem.re && !blocked) begin
            rdata_q <= ram[mem.raddr];
        end
    end

    // Clamp outputs low across the isolation boundary
    assign mem.rdata = blocked ? '0 : rdata_q;

    // The pipe must hold off while the switch is open
    a_no_access_when_off: assert property (
        @(posedge clk) disable iff (!rst_n)
        pwr_enable_b_out |-> !(mem.re || mem.we)
    );

endmodule

`default_nettype wire

// ==== hw/wd_rf_pg_cont.sv ====
`timescale 1ns/100ps
`default_nettype none

module wd_rf_pg_cont (
     input  logic         clk
    ,input  logic         rst_n
    ,input  logic         isol_en
    ,input  logic         pwr_enable_b_in
    ,wd_rmw_if.mem        dir_mem
    ,wd_rmw_if.mem        ldb_mem
    ,output logic         pwr_enable_b_out
);

    logic dir_pwr_enable_b;
    logic ldb_pwr_enable_b;

    // ========================================
    // Directed count memory
    // ========================================

    wd_rf_64x10 i_rf_count_rmw_pipe_wd_dir_mem (
         .clk                 (clk)
        ,.rst_n               (rst_n)
        ,.isol_en             (isol_en)
        ,.pwr_enable_b_in     (pwr_enable_b_in)
        ,.mem                 (dir_mem)
        ,.pwr_enable_b_out    (dir_pwr_enable_b)
    );

    // ========================================
    // Load-balanced count memory
    // ========================================

    // Powers up behind the directed memory to stagger inrush
    wd_rf_64x10 i_rf_count_rmw_pipe_wd_ldb_mem (
         .clk                 (clk)
        ,.rst_n               (rst_n)
        ,.isol_en             (isol_en)
        ,.pwr_enable_b_in     (dir_pwr_enable_b)
        ,.mem                 (ldb_mem)
        ,.pwr_enable_b_out    (ldb_pwr_enable_b)
    );

    // High while either memory is off or the pair is isolated
    assign pwr_enable_b_out = dir_pwr_enable_b | ldb_pwr_enable_b | isol_en;

endmodule

`default_nettype wire

// ==== hw/wd_count_rmw_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module wd_count_rmw_pipe (
     input  logic                     clk
    ,input  logic                     rst_n
    ,input  wd_pkg::rmw_op_t          issue_op
    ,input  logic                     issue_dir_en
    ,input  logic                     issue_ldb_en
    ,input  logic [wd_pkg::qid_w-1:0] issue_qid
    ,input  logic [wd_pkg::cnt_w-1:0] wd_thresh
    ,wd_rmw_if.pipe                   dir_port
    ,wd_rmw_if.pipe                   ldb_port
    ,output logic                     timeout_dir
    ,output logic                     timeout_ldb
    ,output logic [wd_pkg::qid_w-1:0] timeout_qid
    ,output logic                     rd_valid
    ,output logic [wd_pkg::cnt_w-1:0] rd_count
);

    // Lane 0 is directed, lane 1 is load-balanced
    logic [1:0]               issue_en;
    logic [1:0]               rd_en;
    wd_pkg::rmw_op_t          p2_op;
    logic [1:0]               p2_en;
    logic [wd_pkg::qid_w-1:0] p2_qid;
    logic [1:0]               p3_we;
    logic [wd_pkg::qid_w-1:0] p3_qid;
    logic [wd_pkg::cnt_w-1:0] p3_data [2];
    logic [1:0]               p4_we;
    logic [wd_pkg::qid_w-1:0] p4_qid;
    logic [wd_pkg::cnt_w-1:0] p4_data [2];
    logic [wd_pkg::cnt_w-1:0] rdata [2];
    logic [wd_pkg::cnt_w-1:0] cur [2];
    logic [wd_pkg::cnt_w-1:0] nxt [2];
    logic [1:0]               hit;

    // ========================================
    // Stage 1, read request
    // ========================================

    assign issue_en = {issue_ldb_en, issue_dir_en};
    assign rd_en    = (issue_op inside {wd_pkg::op_incr, wd_pkg::op_read}) ? issue_en : 2'b00;

    assign dir_port.re    = rd_en[0];
    assign dir_port.raddr = issue_qid;
    assign ldb_port.re    = rd_en[1];
    assign ldb_port.raddr = issue_qid;

    assign rdata[0] = dir_port.rdata;
    assign rdata[1] = ldb_port.rdata;

    // ========================================
    // Stage 2, forward and modify
    // ========================================

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // p3 is being written now, p4 landed as rdata was sampled
            if (p3_we[i] && (p3_qid == p2_qid)) begin
                cur[i] = p3_data[i];
            end else if (p4_we[i] && (p4_qid == p2_qid)) begin
                cur[i] = p4_data[i];
            end else begin
                cur[i] = rdata[i];
            end
            nxt[i] = cur[i];
            hit[i] = 1'b0;
            if (p2_en[i]) begin
                case (p2_op)
                    wd_pkg::op_zero: nxt[i] = '0;
                    wd_pkg::op_incr: begin
                        if (cur[i] < wd_thresh) begin
                            nxt[i] = cur[i] + 1'b1;
                            hit[i] = (nxt[i] == wd_thresh);
                        end
                    end
                    default: nxt[i] = cur[i];
                endcase
            end
        end
    end

    // ========================================
    // Stage 3, write back and report
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            p2_op       <= wd_pkg::op_none;
            p2_en       <= 2'b00;
            p3_we       <= 2'b00;
            p4_we       <= 2'b00;
            timeout_dir <= 1'b0;
            timeout_ldb <= 1'b0;
            rd_valid    <= 1'b0;
        end else begin
            p2_op       <= issue_op;
            p2_en       <= issue_en;
            p3_we       <= (p2_op inside {wd_pkg::op_zero, wd_pkg::op_incr}) ? p2_en : 2'b00;
            p4_we       <= p3_we;
            timeout_dir <= hit[0];
            timeout_ldb <= hit[1];
            rd_valid    <= (p2_op == wd_pkg::op_read) && (p2_en != 2'b00);
        end
    end

    always_ff @(posedge clk) begin
        p2_qid      <= issue_qid;
        p3_qid      <= p2_qid;
        p4_qid      <= p3_qid;
        timeout_qid <= p2_qid;
        rd_count    <= p2_en[1] ? cur[1] : cur[0];
        for (int i = 0; i < 2; i++) begin
            p3_data[i] <= nxt[i];
            p4_data[i] <= p3_data[i];
        end
    end

    assign dir_port.we    = p3_we[0];
    assign dir_port.waddr = p3_qid;
    assign dir_port.wdata = p3_data[0];
    assign ldb_port.we    = p3_we[1];
    assign ldb_port.waddr = p3_qid;
    assign ldb_port.wdata = p3_data[1];

    // A write goes out exactly two cycles after its issue
    property p_write_issued(logic we, logic [wd_pkg::qid_w-1:0] waddr, logic en);
        @(posedge clk) disable iff (!rst_n)
        we |-> $past(en && (issue_op inside {wd_pkg::op_zero, wd_pkg::op_incr}), 2)
            && ($past(issue_qid, 2) == waddr);
    endproperty

    a_dir_write_issued: assert property (p_write_issued(dir_port.we, dir_port.waddr,
                                                        issue_dir_en));
    a_ldb_write_issued: assert property (p_write_issued(ldb_port.we, ldb_port.waddr,
                                                        issue_ldb_en));

endmodule

`default_nettype wire

// ==== hw/wd_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module wd_ctrl (
     input  logic                     clk
    ,input  logic                     rst_n
    ,input  logic                     tick
    ,input  logic                     deq
    ,input  logic                     deq_qtype
    ,input  logic [wd_pkg::qid_w-1:0] deq_qid
    ,input  logic                     rd
    ,input  logic                     rd_qtype
    ,input  logic [wd_pkg::qid_w-1:0] rd_qid
    ,input  logic                     isol_en
    ,input  logic                     pwr_enable_b_out
    ,output wd_pkg::rmw_op_t          issue_op
    ,output logic                     issue_dir_en
    ,output logic                     issue_ldb_en
    ,output logic [wd_pkg::qid_w-1:0] issue_qid
    ,output logic                     ready
    ,output logic                     sweep_busy
);

    logic                     init_done;
    logic [wd_pkg::qid_w-1:0] idx;
    logic                     idx_last;
    logic                     pwr_ok;
    logic                     init_go;
    logic                     deq_go;
    logic                     rd_go;
    logic                     sweep_step;

    // ========================================
    // Scheduling
    // ========================================

    assign pwr_ok   = !pwr_enable_b_out && !isol_en;
    assign ready    = init_done && pwr_ok;
    assign idx_last = (idx == wd_pkg::qid_w'(wd_pkg::num_qid - 1));

    assign init_go    = !init_done && pwr_ok;
    assign deq_go     = ready && deq;
    // deq beats rd, both beat the sweep
    assign rd_go      = ready && rd && !deq;
    assign sweep_step = ready && (sweep_busy || tick) && !deq_go && !rd_go;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_done    <= 1'b0;
            sweep_busy   <= 1'b0;
            idx          <= '0;
            issue_op     <= wd_pkg::op_none;
            issue_dir_en <= 1'b0;
            issue_ldb_en <= 1'b0;
        end else begin
            issue_op     <= wd_pkg::op_none;
            issue_dir_en <= 1'b0;
            issue_ldb_en <= 1'b0;
            if (!pwr_ok) begin
                // Contents are lost, so zero again once power returns
                init_done  <= 1'b0;
                sweep_busy <= 1'b0;
                idx        <= '0;
            end else if (init_go) begin
                issue_op     <= wd_pkg::op_zero;
                issue_dir_en <= 1'b1;
                issue_ldb_en <= 1'b1;
                idx          <= idx + 1'b1;
                init_done    <= idx_last;
            end else begin
                if (tick && !sweep_busy) begin
                    sweep_busy <= 1'b1;
                end
                if (deq_go) begin
                    issue_op     <= wd_pkg::op_zero;
                    issue_dir_en <= (deq_qtype == wd_pkg::qtype_dir);
                    issue_ldb_en <= (deq_qtype == wd_pkg::qtype_ldb);
                end else if (rd_go) begin
                    issue_op     <= wd_pkg::op_read;
                    issue_dir_en <= (rd_qtype == wd_pkg::qtype_dir);
                    issue_ldb_en <= (rd_qtype == wd_pkg::qtype_ldb);
                end else if (sweep_step) begin
                    issue_op     <= wd_pkg::op_incr;
                    issue_dir_en <= 1'b1;
                    issue_ldb_en <= 1'b1;
                    idx          <= idx + 1'b1;
                    if (idx_last) begin
                        sweep_busy <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deq_go) begin
            issue_qid <= deq_qid;
        end else if (rd_go) begin
            issue_qid <= rd_qid;
        end else begin
            issue_qid <= idx;
        end
    end

    // A sweep ends only with the step for the last index
    a_sweep_ends_last: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($fell(sweep_busy) && ready) |-> (issue_op == wd_pkg::op_incr)
            && (issue_qid == wd_pkg::qid_w'(wd_pkg::num_qid - 1))
    );

endmodule

`default_nettype wire

// ==== hw/wd_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module wd_top (
     input  logic                     clk
    ,input  logic                     rst_n
    ,input  logic                     tick
    ,input  logic                     deq
    ,input  logic                     deq_qtype
    ,input  logic [wd_pkg::qid_w-1:0] deq_qid
    ,input  logic                     rd
    ,input  logic                     rd_qtype
    ,input  logic [wd_pkg::qid_w-1:0] rd_qid
    ,output logic                     rd_valid
    ,output logic [wd_pkg::cnt_w-1:0] rd_count
    ,input  logic [wd_pkg::cnt_w-1:0] wd_thresh
    ,output logic                     timeout_dir
    ,output logic                     timeout_ldb
    ,output logic [wd_pkg::qid_w-1:0] timeout_qid
    ,output logic                     ready
    ,output logic                     sweep_busy
    ,input  logic                     isol_en
    ,input  logic                     pwr_enable_b_in
    ,output logic                     pwr_enable_b_out
);

    wd_pkg::rmw_op_t          issue_op;
    logic                     issue_dir_en;
    logic                     issue_ldb_en;
    logic [wd_pkg::qid_w-1:0] issue_qid;

    wd_rmw_if dir_rmw ();
    wd_rmw_if ldb_rmw ();

    wd_ctrl i_ctrl (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.tick             (tick)
        ,.deq              (deq)
        ,.deq_qtype        (deq_qtype)
        ,.deq_qid          (deq_qid)
        ,.rd               (rd)
        ,.rd_qtype         (rd_qtype)
        ,.rd_qid           (rd_qid)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.issue_op         (issue_op)
        ,.issue_dir_en     (issue_dir_en)
        ,.issue_ldb_en     (issue_ldb_en)
        ,.issue_qid        (issue_qid)
        ,.ready            (ready)
        ,.sweep_busy       (sweep_busy)
    );

    wd_count_rmw_pipe i_count_rmw_pipe (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.issue_op         (issue_op)
        ,.issue_dir_en     (issue_dir_en)
        ,.issue_ldb_en     (issue_ldb_en)
        ,.issue_qid        (issue_qid)
        ,.wd_thresh        (wd_thresh)
        ,.dir_port         (dir_rmw.pipe)
        ,.ldb_port         (ldb_rmw.pipe)
        ,.timeout_dir      (timeout_dir)
        ,.timeout_ldb      (timeout_ldb)
        ,.timeout_qid      (timeout_qid)
        ,.rd_valid         (rd_valid)
        ,.rd_count         (rd_count)
    );

    wd_rf_pg_cont i_rf_pg_cont (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.dir_mem          (dir_rmw.mem)
        ,.ldb_mem          (ldb_rmw.mem)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

endmodule

`default_nettype wire

// ==== bench/wd_check.sv ====
`timescale 1ns/100ps
`default_nettype none

module wd_check (
     input  logic                     clk
    ,input  logic                     rst_n
    ,input  logic                     rd_valid
    ,input  logic [wd_pkg::cnt_w-1:0] rd_count
    ,input  logic                     timeout_dir
    ,input  logic                     timeout_ldb
    ,input  logic [wd_pkg::qid_w-1:0] timeout_qid
    ,input  logic [wd_pkg::cnt_w-1:0] exp_rd_count
    ,input  logic [wd_pkg::num_qid-1:0] exp_to_dir
    ,input  logic [wd_pkg::num_qid-1:0] exp_to_ldb
    ,input  logic                     check_sweep
    ,output int                       errors
    ,output int                       checks
);

    // Timeouts seen since the last sweep compare
    logic [wd_pkg::num_qid-1:0] obs_dir = '0;
    logic [wd_pkg::num_qid-1:0] obs_ldb = '0;
    int                         err_n   = 0;
    int                         chk_n   = 0;

    assign errors = err_n;
    assign checks = chk_n;

    // Outputs settle on the previous falling edge, so the rising edge sees them stable
    always @(posedge clk) begin
        if (rst_n) begin
            if (rd_valid === 1'b1) begin
                chk_n = chk_n + 1;
                if (rd_count !== exp_rd_count) begin
                    $display("mismatch rd_count: got %h, expected %h", rd_count, exp_rd_count);
                    err_n = err_n + 1;
                end
            end

            // ========================================
            // Timeout collection
            // ========================================

            if (timeout_dir === 1'b1) begin
                if (obs_dir[timeout_qid]) begin
                    $display("directed queue %h timed out twice in one sweep", timeout_qid);
                    err_n = err_n + 1;
                end
                obs_dir[timeout_qid] = 1'b1;
            end
            if (timeout_ldb === 1'b1) begin
                if (obs_ldb[timeout_qid]) begin
                    $display("load-balanced queue %h timed out twice in one sweep",
                             timeout_qid);
                    err_n = err_n + 1;
                end
                obs_ldb[timeout_qid] = 1'b1;
            end

            if (check_sweep === 1'b1) begin
                chk_n = chk_n + 2;
                if (obs_dir !== exp_to_dir) begin
                    $display("mismatch timeout_dir: got %h, expected %h", obs_dir, exp_to_dir);
                    err_n = err_n + 1;
                end
                if (obs_ldb !== exp_to_ldb) begin
                    $display("mismatch timeout_ldb: got %h, expected %h", obs_ldb, exp_to_ldb);
                    err_n = err_n + 1;
                end
                obs_dir = '0;
                obs_ldb = '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/wd_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module wd_tb;

    localparam int n_rounds   = 6;
    localparam int n_rand_ops = 12;
    localparam int n_sweeps   = 6 + n_rounds;
    localparam int n_ops      = 150 + n_rounds * n_rand_ops;
    localparam int wd_cycles  = n_sweeps * 80 + n_ops * 10 + 2000;

    logic                       clk;
    logic                       rst_n;
    logic                       tick;
    logic                       deq;
    logic                       deq_qtype;
    logic [wd_pkg::qid_w-1:0]   deq_qid;
    logic                       rd;
    logic                       rd_qtype;
    logic [wd_pkg::qid_w-1:0]   rd_qid;
    logic                       rd_valid;
    logic [wd_pkg::cnt_w-1:0]   rd_count;
    logic [wd_pkg::cnt_w-1:0]   wd_thresh;
    logic                       timeout_dir;
    logic                       timeout_ldb;
    logic [wd_pkg::qid_w-1:0]   timeout_qid;
    logic                       ready;
    logic                       sweep_busy;
    logic                       isol_en;
    logic                       pwr_enable_b_in;
    logic                       pwr_enable_b_out;

    logic [wd_pkg::cnt_w-1:0]   exp_rd_count;
    logic [wd_pkg::num_qid-1:0] exp_to_dir;
    logic [wd_pkg::num_qid-1:0] exp_to_ldb;
    logic                       check_sweep;
    int                         chk_errors;
    int                         chk_checks;
    int                         fail_count;
    int                         seed;

    // Model counts, first index is the queue type
    logic [wd_pkg::cnt_w-1:0]   model_cnt [2][wd_pkg::num_qid];

    wd_top wd_top_i (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.tick             (tick)
        ,.deq              (deq)
        ,.deq_qtype        (deq_qtype)
        ,.deq_qid          (deq_qid)
        ,.rd               (rd)
        ,.rd_qtype         (rd_qtype)
        ,.rd_qid           (rd_qid)
        ,.rd_valid         (rd_valid)
        ,.rd_count         (rd_count)
        ,.wd_thresh        (wd_thresh)
        ,.timeout_dir      (timeout_dir)
        ,.timeout_ldb      (timeout_ldb)
        ,.timeout_qid      (timeout_qid)
        ,.ready            (ready)
        ,.sweep_busy       (sweep_busy)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    wd_check check_i (
         .clk          (clk)
        ,.rst_n        (rst_n)
        ,.rd_valid     (rd_valid)
        ,.rd_count     (rd_count)
        ,.timeout_dir  (timeout_dir)
        ,.timeout_ldb  (timeout_ldb)
        ,.timeout_qid  (timeout_qid)
        ,.exp_rd_count (exp_rd_count)
        ,.exp_to_dir   (exp_to_dir)
        ,.exp_to_ldb   (exp_to_ldb)
        ,.check_sweep  (check_sweep)
        ,.errors       (chk_errors)
        ,.checks       (chk_checks)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", wd_cycles);
        $display("checks %0d, checker errors %0d, bench errors %0d",
                 chk_checks, chk_errors, fail_count + 1);
        $display("*** FAILED ***");
        $finish;
    end

    // ========================================
    // Reference model
    // ========================================

    // Sweep step of one lane, stops at the threshold
    function automatic logic bump_count(input logic qtype, input logic [wd_pkg::qid_w-1:0] qid);
        if (model_cnt[qtype][qid] < wd_thresh) begin
            model_cnt[qtype][qid] = model_cnt[qtype][qid] + 1'b1;
            return model_cnt[qtype][qid] == wd_thresh;
        end
        return 1'b0;
    endfunction

    // Returns the expected timeouts, bit 0 directed and bit 1 load-balanced
    function automatic logic [1:0] model_step(input logic is_deq, input logic qtype,
                                              input logic [wd_pkg::qid_w-1:0] qid);
        logic [1:0] hit;
        hit = 2'b00;
        if (is_deq) begin
            model_cnt[qtype][qid] = '0;
        end else begin
            hit[0] = bump_count(wd_pkg::qtype_dir, qid);
            hit[1] = bump_count(wd_pkg::qtype_ldb, qid);
        end
        return hit;
    endfunction

    function automatic void clear_model();
        for (int j = 0; j < wd_pkg::num_qid; j++) begin
            model_cnt[0][wd_pkg::qid_w'(j)] = '0;
            model_cnt[1][wd_pkg::qid_w'(j)] = '0;
        end
    endfunction

    // ========================================
    // Stimulus tasks
    // ========================================

    task automatic expect_level(input string name, input logic value, input logic level);
        if (value !== level) begin
            $display("mismatch %s: got %h, expected %h", name, value, level);
            fail_count++;
        end
    endtask

    task automatic wait_ready_level(input logic level);
        int n;
        n = 0;
        while (ready !== level && n < 400) begin
            @(negedge clk);
            n++;
        end
        if (ready !== level) begin
            $display("ready did not go to %0b within %0d cycles", level, n);
            fail_count++;
        end
    endtask

    task automatic wait_read_valid();
        int n;
        n = 0;
        while (rd_valid !== 1'b1 && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (rd_valid !== 1'b1) begin
            $display("no read response within %0d cycles", n);
            fail_count++;
        end
    endtask

    task automatic do_read(input logic qtype, input logic [wd_pkg::qid_w-1:0] qid);
        @(negedge clk);
        exp_rd_count = model_cnt[qtype][qid];
        rd           = 1'b1;
        rd_qtype     = qtype;
        rd_qid       = qid;
        @(negedge clk);
        rd = 1'b0;
        wait_read_valid();
    endtask

    task automatic do_deq(input logic qtype, input logic [wd_pkg::qid_w-1:0] qid);
        @(negedge clk);
        deq       = 1'b1;
        deq_qtype = qtype;
        deq_qid   = qid;
        void'(model_step(1'b1, qtype, qid));
        @(negedge clk);
        deq = 1'b0;
    endtask

    // Read issued the cycle after the dequeue, so it needs the forwarded zero
    task automatic deq_then_read(input logic qtype, input logic [wd_pkg::qid_w-1:0] qid);
        do_deq(qtype, qid);
        exp_rd_count = model_cnt[qtype][qid];
        rd           = 1'b1;
        rd_qtype     = qtype;
        rd_qid       = qid;
        @(negedge clk);
        rd = 1'b0;
        wait_read_valid();
    endtask

    task automatic rand_op(input logic allow_deq);
        logic [31:0] r;
        r = $random(seed);
        if (allow_deq && r[0]) begin
            do_deq(r[1], r[7:2]);
        end else begin
            do_read(r[1], r[7:2]);
        end
    endtask

    // deq_at counts cycles after tick, a negative value means no dequeue
    task automatic run_sweep(input int deq_at, input logic dq_type,
                             input logic [wd_pkg::qid_w-1:0] dq_qid);
        logic [1:0]               hit;
        logic [wd_pkg::qid_w-1:0] q;
        int                       n;
        @(negedge clk);
        tick = 1'b1;
        for (int c = 1; c <= 12; c++) begin
            @(negedge clk);
            tick      = 1'b0;
            deq       = (c == deq_at);
            deq_qtype = dq_type;
            deq_qid   = dq_qid;
            if (c == 1 && sweep_busy !== 1'b1) begin
                $display("sweep did not start after tick");
                fail_count++;
            end
        end
        n = 0;
        while (sweep_busy === 1'b1 && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (sweep_busy === 1'b1) begin
            $display("sweep did not finish within %0d cycles", n);
            fail_count++;
        end
        // Last write and its timeout land two cycles after the final issue
        repeat (4) @(negedge clk);
        exp_to_dir = '0;
        exp_to_ldb = '0;
        for (int j = 0; j < wd_pkg::num_qid; j++) begin
            q = wd_pkg::qid_w'(j);
            // A stalled sweep has issued exactly deq_at indices before the dequeue
            if (j == deq_at) begin
                void'(model_step(1'b1, dq_type, dq_qid));
            end
            hit           = model_step(1'b0, wd_pkg::qtype_dir, q);
            exp_to_dir[q] = hit[0];
            exp_to_ldb[q] = hit[1];
        end
        check_sweep = 1'b1;
        @(negedge clk);
        check_sweep = 1'b0;
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        seed            = 86934;
        fail_count      = 0;
        rst_n           = 1'b0;
        tick            = 1'b0;
        deq             = 1'b0;
        deq_qtype       = wd_pkg::qtype_dir;
        deq_qid         = '0;
        rd              = 1'b0;
        rd_qtype        = wd_pkg::qtype_dir;
        rd_qid          = '0;
        wd_thresh       = 10'd3;
        isol_en         = 1'b0;
        pwr_enable_b_in = 1'b0;
        exp_rd_count    = '0;
        exp_to_dir      = '0;
        exp_to_ldb      = '0;
        check_sweep     = 1'b0;
        clear_model();

        repeat (16) @(negedge clk);
        expect_level("ready", ready, 1'b0);
        expect_level("sweep_busy", sweep_busy, 1'b0);
        expect_level("rd_valid", rd_valid, 1'b0);
        expect_level("timeout_dir", timeout_dir, 1'b0);
        expect_level("timeout_ldb", timeout_ldb, 1'b0);
        rst_n = 1'b1;

        // Init zeroes both memories
        wait_ready_level(1'b1);
        repeat (8) rand_op(1'b0);

        // Timeouts only in the third sweep, then the counts hold at the threshold
        repeat (4) run_sweep(-1, wd_pkg::qtype_dir, '0);
        repeat (8) rand_op(1'b0);

        deq_then_read(wd_pkg::qtype_ldb, 6'd17);
        deq_then_read(wd_pkg::qtype_dir, 6'd42);

        // Dequeues racing a sweep
        run_sweep(1, wd_pkg::qtype_dir, 6'd63);
        do_read(wd_pkg::qtype_dir, 6'd63);
        run_sweep(10, wd_pkg::qtype_dir, 6'd0);
        do_read(wd_pkg::qtype_dir, 6'd0);

        for (int i = 0; i < n_rounds; i++) begin
            repeat (n_rand_ops) rand_op(1'b1);
            run_sweep(-1, wd_pkg::qtype_dir, '0);
        end

        // Power cycle, contents come back zeroed
        repeat (4) @(negedge clk);
        pwr_enable_b_in = 1'b1;
        @(negedge clk);
        expect_level("pwr_enable_b_out", pwr_enable_b_out, 1'b1);
        wait_ready_level(1'b0);
        repeat (8) @(negedge clk);
        pwr_enable_b_in = 1'b0;
        // Load-balanced memory powers up one cycle behind the directed one
        @(negedge clk);
        expect_level("pwr_enable_b_out", pwr_enable_b_out, 1'b1);
        @(negedge clk);
        expect_level("pwr_enable_b_out", pwr_enable_b_out, 1'b0);
        wait_ready_level(1'b1);
        clear_model();
        for (int j = 0; j < wd_pkg::num_qid; j++) begin
            do_read(wd_pkg::qtype_dir, wd_pkg::qid_w'(j));
            do_read(wd_pkg::qtype_ldb, wd_pkg::qid_w'(j));
        end

        repeat (4) @(negedge clk);
        $display("checks %0d, checker errors %0d, bench errors %0d",
                 chk_checks, chk_errors, fail_count);
        if (chk_errors == 0 && fail_count == 0 && chk_checks > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/wd_pkg.sv
hw/wd_rmw_if.sv
hw/wd_rf_64x10.sv
hw/wd_rf_pg_cont.sv
hw/wd_count_rmw_pipe.sv
hw/wd_ctrl.sv
hw/wd_top.sv
bench/wd_check.sv
bench/wd_tb.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat vlog.f))

.PHONY: run clean

run: obj_dir/Vwd_tb
	@out="$$(./obj_dir/Vwd_tb)"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

obj_dir/Vwd_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module wd_tb -f vlog.f -o Vwd_tb

clean:
	rm -rf obj_dir
